/* build.f */
hw/lms_pkg.sv
hw/lms_rx_capture.sv
hw/lms_tx_interleave.sv
hw/spi_select.sv
hw/board_status.sv
hw/lms_frontend_top.sv
testbench/tb_lms_frontend.sv

/* hw/board_status.sv */
//======================================================================
// Board status, clock generator reset pulse and LED polarity outputs
//======================================================================

`timescale 1ns/1ps
`default_nettype none

module board_status
   import lms_pkg::*;
(
   input  wire              dsp_clk,
   input  wire              rst_i,
   input  wire              clock_ready_i,
   input  wire  [LED_W-1:0] leds_i,
   output logic             pll_rst_o,
   output logic [LED_W-2:0] leds_n_o,
   output logic             eth_led_o
);

   logic [READY_SYNC_LEN-1:0] ready_hist_q;
   logic [LED_W-1:0]          leds_q;

   // Newest sample enters at bit 0
   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
         ready_hist_q <= '0;
      else
         ready_hist_q <= {ready_hist_q[READY_SYNC_LEN-2:0], clock_ready_i};
   end

   // Pulse lasts while the rising edge travels through the history
   assign pll_rst_o = (|ready_hist_q) & ~(&ready_hist_q);

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
         leds_q <= LED_POLARITY_MASK;   // All LEDs off
      else
         leds_q <= leds_i ^ LED_POLARITY_MASK;
   end

   assign leds_n_o  = leds_q[LED_W-2:0];
   assign eth_led_o = leds_q[LED_W-1];   // Keeps core polarity

endmodule

`default_nettype wire

/* hw/lms_frontend_top.sv */
//======================================================================
// LMS front end top, radio-facing edge between the DSP core and the
// two LMS transceivers, SPI slaves and board status pins
//======================================================================

`timescale 1ns/1ps
`default_nettype none

module lms_frontend_top
   import lms_pkg::*;
(
   input  wire                       dsp_clk,
   input  wire                       rst_i,

   // Receive channels from the LMS chips
   input  logic                      rx_iqsel_i [NUM_CHAN],
   input  sample_t                   rx_data_i  [NUM_CHAN],
   output adc_word_t                 adc_i_o    [NUM_CHAN],
   output adc_word_t                 adc_q_o    [NUM_CHAN],

   // Transmit channels to the LMS chips
   input  dac_word_t                 dac_i_i    [NUM_CHAN],
   input  dac_word_t                 dac_q_i    [NUM_CHAN],
   output sample_t                   tx_data_o  [NUM_CHAN],
   output logic                      tx_iqsel_o [NUM_CHAN],

   // SPI master side and slave side
   input  wire                       spi_sclk_i,
   input  wire                       spi_mosi_i,
   input  wire  [NUM_SPI_SLAVES-1:0] spi_sen_n_i,
   input  wire  [NUM_SPI_SLAVES-1:0] spi_miso_i,
   output logic [NUM_SPI_SLAVES-1:0] slave_sclk_o,
   output logic [NUM_SPI_SLAVES-1:0] slave_mosi_o,
   output logic                      spi_miso_o,

   // Clock generator and LEDs
   input  wire                       clock_ready_i,
   input  wire  [LED_W-1:0]          leds_i,
   output logic                      pll_rst_o,
   output logic [LED_W-2:0]          leds_n_o,
   output logic                      eth_led_o
);

   lms_rx_capture u_rx_capture
   (
      .dsp_clk    (dsp_clk),
      .rst_i      (rst_i),
      .rx_iqsel_i (rx_iqsel_i),
      .rx_data_i  (rx_data_i),
      .adc_i_o    (adc_i_o),
      .adc_q_o    (adc_q_o)
   );

   lms_tx_interleave u_tx_interleave
   (
      .dsp_clk    (dsp_clk),
      .rst_i      (rst_i),
      .dac_i_i    (dac_i_i),
      .dac_q_i    (dac_q_i),
      .tx_data_o  (tx_data_o),
      .tx_iqsel_o (tx_iqsel_o)
   );

   // Combinational, no clock
   spi_select u_spi_select
   (
      .spi_sclk_i   (spi_sclk_i),
      .spi_mosi_i   (spi_mosi_i),
      .spi_sen_n_i  (spi_sen_n_i),
      .spi_miso_i   (spi_miso_i),
      .slave_sclk_o (slave_sclk_o),
      .slave_mosi_o (slave_mosi_o),
      .spi_miso_o   (spi_miso_o)
   );

   board_status u_board_status
   (
      .dsp_clk       (dsp_clk),
      .rst_i         (rst_i),
      .clock_ready_i (clock_ready_i),
      .leds_i        (leds_i),
      .pll_rst_o     (pll_rst_o),
      .leds_n_o      (leds_n_o),
      .eth_led_o     (eth_led_o)
   );

endmodule

`default_nettype wire

/* hw/lms_pkg.sv */
//======================================================================
// LMS front end shared widths, counts and sample types
//======================================================================

`default_nettype none

package lms_pkg;

   // Transceiver channels per board
   localparam int NUM_CHAN = 2;

   // Chip-side and core-side word widths
   localparam int SAMPLE_W = 12;   // LMS sample bus
   localparam int ADC_W    = 14;   // Core ADC port
   localparam int DAC_W    = 16;   // Core DAC port

   // SPI slaves sharing the one master
   localparam int NUM_SPI_SLAVES = 3;
   localparam int SPI_DAC        = 0;
   localparam int SPI_LMS1       = 1;
   localparam int SPI_LMS2       = 2;

   // Clock-ready history depth
   localparam int READY_SYNC_LEN = 6;

   // LED word, top bit is the Ethernet LED
   localparam int LED_W = 6;

   // Board LEDs are active low, Ethernet LED is not
   localparam logic [LED_W-1:0] LED_POLARITY_MASK = 6'b011111;

   typedef logic [SAMPLE_W-1:0] sample_t;     // Chip-side sample
   typedef logic [ADC_W-1:0]    adc_word_t;   // Core ADC word
   typedef logic [DAC_W-1:0]    dac_word_t;   // Core DAC word

endpackage

`default_nettype wire

/* hw/lms_rx_capture.sv */
//======================================================================
// LMS receive capture, splits the I/Q muxed sample bus of each channel
// into core-width I and Q words
//======================================================================

`timescale 1ns/1ps
`default_nettype none

module lms_rx_capture
   import lms_pkg::*;
(
   input  wire       dsp_clk,
   input  wire       rst_i,
   input  logic      rx_iqsel_i [NUM_CHAN],   // Low for I, high for Q
   input  sample_t   rx_data_i  [NUM_CHAN],
   output adc_word_t adc_i_o    [NUM_CHAN],
   output adc_word_t adc_q_o    [NUM_CHAN]
);

   localparam int PAD_W = ADC_W - SAMPLE_W;

   genvar ch;

   generate
      for (ch = 0; ch < NUM_CHAN; ch++)
      begin : g_chan
         adc_word_t sample_ext;
         adc_word_t i_q;
         adc_word_t q_q;

         // Samples are unsigned on this bus, so pad with zeros
         assign sample_ext = {{PAD_W{1'b0}}, rx_data_i[ch]};

         always_ff @(posedge dsp_clk)
         begin
            if (rst_i)
            begin
               i_q <= '0;
               q_q <= '0;
            end
            else if (rx_iqsel_i[ch] == 1'b0)
               i_q <= sample_ext;
            else
               q_q <= sample_ext;   // Other word holds
         end

         assign adc_i_o[ch] = i_q;
         assign adc_q_o[ch] = q_q;
      end
   endgenerate

endmodule

`default_nettype wire

/* hw/lms_tx_interleave.sv */
//======================================================================
// LMS transmit interleave, sends I and Q words of each channel on
// alternate cycles with the matching select line
//======================================================================

`timescale 1ns/1ps
`default_nettype none

module lms_tx_interleave
   import lms_pkg::*;
(
   input  wire       dsp_clk,
   input  wire       rst_i,
   input  dac_word_t dac_i_i    [NUM_CHAN],
   input  dac_word_t dac_q_i    [NUM_CHAN],
   output sample_t   tx_data_o  [NUM_CHAN],
   output logic      tx_iqsel_o [NUM_CHAN]
);

   // Half-rate phase, low means the next load is I
   logic phase_q;

   always_ff @(posedge dsp_clk)
   begin
      if (rst_i)
         phase_q <= 1'b0;
      else
         phase_q <= ~phase_q;
   end

   genvar ch;

   generate
      for (ch = 0; ch < NUM_CHAN; ch++)
      begin : g_chan
         sample_t data_q;
         logic    iqsel_q;

         // Only the low bits reach the chip DAC
         always_ff @(posedge dsp_clk)
         begin
            if (rst_i)
            begin
               data_q  <= '0;
               iqsel_q <= 1'b1;   // Looks like Q so the first word is I
            end
            else if (phase_q == 1'b0)
            begin
               data_q  <= dac_i_i[ch][SAMPLE_W-1:0];
               iqsel_q <= 1'b0;
            end
            else
            begin
               data_q  <= dac_q_i[ch][SAMPLE_W-1:0];
               iqsel_q <= 1'b1;
            end
         end

         assign tx_data_o[ch]  = data_q;
         assign tx_iqsel_o[ch] = iqsel_q;
      end
   endgenerate

endmodule

`default_nettype wire

/* hw/spi_select.sv */
//======================================================================
// SPI fan-out, gates the shared master to each slave and merges MISO
//======================================================================

`timescale 1ns/1ps
`default_nettype none

module spi_select
   import lms_pkg::*;
(
   input  wire                       spi_sclk_i,
   input  wire                       spi_mosi_i,
   input  wire  [NUM_SPI_SLAVES-1:0] spi_sen_n_i,    // Active-low enables
   input  wire  [NUM_SPI_SLAVES-1:0] spi_miso_i,
   output logic [NUM_SPI_SLAVES-1:0] slave_sclk_o,
   output logic [NUM_SPI_SLAVES-1:0] slave_mosi_o,
   output logic                      spi_miso_o
);

   logic [NUM_SPI_SLAVES-1:0] slave_en;
   logic [NUM_SPI_SLAVES-1:0] miso_gated;

   assign slave_en = ~spi_sen_n_i;

   genvar s;

   generate
      for (s = 0; s < NUM_SPI_SLAVES; s++)
      begin : g_slave
         // Idle slaves see clock and data held low
         assign slave_sclk_o[s] = slave_en[s] ? spi_sclk_i : 1'b0;
         assign slave_mosi_o[s] = slave_en[s] ? spi_mosi_i : 1'b0;

         // Unselected slaves may float MISO
         assign miso_gated[s] = slave_en[s] & spi_miso_i[s];
      end
   endgenerate

   assign spi_miso_o = |miso_gated;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the LMS front end testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit 1
fi

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module tb_lms_frontend \
   -Mdir "$OBJ" -o sim \
   -f build.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
   exit 1
fi

exit 0

/* testbench/tb_lms_frontend.sv */
//======================================================================
// Testbench for the LMS front end with reference models and assertions
// covering RX, TX, SPI fan-out, clock-ready pulse and LED outputs
//======================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_lms_frontend
   import lms_pkg::*;
();

   localparam int CLK_HALF = 10;
   localparam int T_RX  = 0;
   localparam int T_TX  = 1;
   localparam int T_SPI = 2;
   localparam int T_PLL = 3;
   localparam int T_LED = 4;

   logic                      dsp_clk;
   logic                      rst_i;
   logic                      rx_iqsel [NUM_CHAN];
   sample_t                   rx_data  [NUM_CHAN];
   adc_word_t                 adc_i    [NUM_CHAN];
   adc_word_t                 adc_q    [NUM_CHAN];
   dac_word_t                 dac_i    [NUM_CHAN];
   dac_word_t                 dac_q    [NUM_CHAN];
   sample_t                   tx_data  [NUM_CHAN];
   logic                      tx_iqsel [NUM_CHAN];
   logic                      spi_sclk;
   logic                      spi_mosi;
   logic [NUM_SPI_SLAVES-1:0] spi_sen_n;
   logic [NUM_SPI_SLAVES-1:0] spi_miso_in;
   logic [NUM_SPI_SLAVES-1:0] slave_sclk;
   logic [NUM_SPI_SLAVES-1:0] slave_mosi;
   logic                      spi_miso_out;
   logic                      clock_ready;
   logic [LED_W-1:0]          leds;
   logic                      pll_rst;
   logic [LED_W-2:0]          leds_n;
   logic                      eth_led;

   // Reference model state
   adc_word_t                 exp_adc_i    [NUM_CHAN];
   adc_word_t                 exp_adc_q    [NUM_CHAN];
   sample_t                   exp_tx_data  [NUM_CHAN];
   logic                      exp_tx_iqsel [NUM_CHAN];
   logic [READY_SYNC_LEN-1:0] exp_ready_hist;
   logic [LED_W-2:0]          exp_leds_n;
   logic                      exp_eth_led;

   int          err_count [5];
   int          timeout_count;
   bit          checks_on;

   lms_frontend_top UUT
   (
      .dsp_clk       (dsp_clk),
      .rst_i         (rst_i),
      .rx_iqsel_i    (rx_iqsel),
      .rx_data_i     (rx_data),
      .adc_i_o       (adc_i),
      .adc_q_o       (adc_q),
      .dac_i_i       (dac_i),
      .dac_q_i       (dac_q),
      .tx_data_o     (tx_data),
      .tx_iqsel_o    (tx_iqsel),
      .spi_sclk_i    (spi_sclk),
      .spi_mosi_i    (spi_mosi),
      .spi_sen_n_i   (spi_sen_n),
      .spi_miso_i    (spi_miso_in),
      .slave_sclk_o  (slave_sclk),
      .slave_mosi_o  (slave_mosi),
      .spi_miso_o    (spi_miso_out),
      .clock_ready_i (clock_ready),
      .leds_i        (leds),
      .pll_rst_o     (pll_rst),
      .leds_n_o      (leds_n),
      .eth_led_o     (eth_led)
   );

   initial dsp_clk = 1'b0;
   always #CLK_HALF dsp_clk = ~dsp_clk;

   task automatic note_mismatch(input int test, input string what, input int idx,
                                input logic [31:0] expected, input logic [31:0] actual);
      $display("FAILED %s[%0d]: expected %0h, actual %0h", what, idx, expected, actual);
      err_count[test]++;
   endtask

   // Reference models step on the same edge as the DUT
   always @(posedge dsp_clk)
   begin
      for (int ch = 0; ch < NUM_CHAN; ch++)
      begin
         if (rst_i)
         begin
            exp_adc_i[ch]    <= '0;
            exp_adc_q[ch]    <= '0;
            exp_tx_data[ch]  <= '0;
            exp_tx_iqsel[ch] <= 1'b1;
         end
         else
         begin
            if (!rx_iqsel[ch])
               exp_adc_i[ch] <= {{(ADC_W-SAMPLE_W){1'b0}}, rx_data[ch]};
            else
               exp_adc_q[ch] <= {{(ADC_W-SAMPLE_W){1'b0}}, rx_data[ch]};
            exp_tx_iqsel[ch] <= ~exp_tx_iqsel[ch];   // I follows Q
            exp_tx_data[ch]  <= exp_tx_iqsel[ch] ? dac_i[ch][SAMPLE_W-1:0]
                                                 : dac_q[ch][SAMPLE_W-1:0];
         end
      end
      if (rst_i)
      begin
         exp_ready_hist <= '0;
         exp_leds_n     <= '1;   // Dark
         exp_eth_led    <= 1'b0;
      end
      else
      begin
         exp_ready_hist <= {exp_ready_hist[READY_SYNC_LEN-2:0], clock_ready};
         exp_leds_n     <= ~leds[LED_W-2:0];
         exp_eth_led    <= leds[LED_W-1];
      end
   end

   // Outputs are stable mid-cycle
   always @(negedge dsp_clk)
   begin
      logic [NUM_SPI_SLAVES-1:0] exp_sclk;
      logic [NUM_SPI_SLAVES-1:0] exp_mosi;
      logic                      exp_miso;
      logic                      exp_pll;
      if (checks_on)
      begin
         for (int ch = 0; ch < NUM_CHAN; ch++)
         begin
            assert (adc_i[ch] == exp_adc_i[ch])
               else note_mismatch(T_RX, "rx adc_i", ch, 32'(exp_adc_i[ch]), 32'(adc_i[ch]));
            assert (adc_q[ch] == exp_adc_q[ch])
               else note_mismatch(T_RX, "rx adc_q", ch, 32'(exp_adc_q[ch]), 32'(adc_q[ch]));
            assert (tx_iqsel[ch] == exp_tx_iqsel[ch])
               else note_mismatch(T_TX, "tx iqsel", ch, 32'(exp_tx_iqsel[ch]),
                                  32'(tx_iqsel[ch]));
            assert (tx_data[ch] == exp_tx_data[ch])
               else note_mismatch(T_TX, "tx data", ch, 32'(exp_tx_data[ch]), 32'(tx_data[ch]));
         end
         exp_miso = 1'b0;
         for (int s = 0; s < NUM_SPI_SLAVES; s++)
         begin
            exp_sclk[s] = spi_sen_n[s] ? 1'b0 : spi_sclk;
            exp_mosi[s] = spi_sen_n[s] ? 1'b0 : spi_mosi;
            exp_miso    = exp_miso | (~spi_sen_n[s] & spi_miso_in[s]);
         end
         assert (slave_sclk == exp_sclk)
            else note_mismatch(T_SPI, "spi sclk", 0, 32'(exp_sclk), 32'(slave_sclk));
         assert (slave_mosi == exp_mosi)
            else note_mismatch(T_SPI, "spi mosi", 0, 32'(exp_mosi), 32'(slave_mosi));
         assert (spi_miso_out == exp_miso)
            else note_mismatch(T_SPI, "spi miso", 0, 32'(exp_miso), 32'(spi_miso_out));
         // Pulse while the history is partly filled
         exp_pll = (exp_ready_hist != '0) && (exp_ready_hist != '1);
         assert (pll_rst == exp_pll)
            else note_mismatch(T_PLL, "pll_rst", 0, 32'(exp_pll), 32'(pll_rst));
         assert (leds_n == exp_leds_n)
            else note_mismatch(T_LED, "leds_n", 0, 32'(exp_leds_n), 32'(leds_n));
         assert (eth_led == exp_eth_led)
            else note_mismatch(T_LED, "eth_led", 0, 32'(exp_eth_led), 32'(eth_led));
      end
   end

   task automatic drive_random(input bit with_ready);
      logic [31:0] r;
      for (int ch = 0; ch < NUM_CHAN; ch++)
      begin
         r            = $urandom();
         rx_iqsel[ch] = r[31];
         rx_data[ch]  = r[SAMPLE_W-1:0];
         r            = $urandom();
         dac_i[ch]    = r[DAC_W-1:0];
         dac_q[ch]    = r[31:32-DAC_W];
      end
      r           = $urandom();
      spi_sclk    = r[0];
      spi_mosi    = r[1];
      spi_sen_n   = r[4:2];
      spi_miso_in = r[7:5];
      leds        = r[13:8];
      if (with_ready)
         clock_ready = r[20];
   endtask

   task automatic run_cycles(input int n, input bit with_ready);
      repeat (n)
      begin
         drive_random(with_ready);
         @(posedge dsp_clk);
         #1;
      end
   endtask

   // Pulse width of pll_rst_o after a held rising clock_ready
   task automatic check_ready_pulse();
      bit seen;
      int width;
      seen  = 1'b0;
      width = 0;
      clock_ready = 1'b1;
      for (int i = 0; i < 20; i++)
      begin
         @(negedge dsp_clk);
         if (pll_rst)
         begin
            seen = 1'b1;
            break;
         end
      end
      if (!seen)
      begin
         $display("Timeout: pll_rst_o never rose after clock_ready went high");
         timeout_count++;
      end
      else
      begin
         width = 1;
         for (int i = 0; i < 20; i++)
         begin
            @(negedge dsp_clk);
            if (!pll_rst)
               break;
            width++;
         end
         assert (width == READY_SYNC_LEN - 1)
            else note_mismatch(T_PLL, "pll pulse width", 0, 32'(READY_SYNC_LEN - 1),
                               32'(width));
         repeat (10)
         begin
            @(negedge dsp_clk);
            assert (!pll_rst)
               else note_mismatch(T_PLL, "pll low after pulse", 0, 32'd0, 32'(pll_rst));
         end
      end
      @(posedge dsp_clk);
      #1;
   endtask

   initial
   begin
      int total;
      rst_i       = 1'b1;
      checks_on   = 1'b0;
      spi_sclk    = 1'b0;
      spi_mosi    = 1'b0;
      spi_sen_n   = '1;
      spi_miso_in = '0;
      clock_ready = 1'b0;
      leds        = '0;
      for (int ch = 0; ch < NUM_CHAN; ch++)
      begin
         rx_iqsel[ch] = 1'b0;
         rx_data[ch]  = '0;
         dac_i[ch]    = '0;
         dac_q[ch]    = '0;
      end
      timeout_count = 0;
      void'($urandom(32'h7ffb));

      @(posedge dsp_clk);
      #1;
      checks_on = 1'b1;   // Reset values are checked from here on
      @(posedge dsp_clk);
      #1;
      rst_i = 1'b0;

      run_cycles(200, 1'b0);
      check_ready_pulse();
      run_cycles(150, 1'b1);

      // Reset again in the middle of traffic
      rst_i = 1'b1;
      run_cycles(2, 1'b1);
      rst_i = 1'b0;
      clock_ready = 1'b0;
      run_cycles(60, 1'b0);

      total = timeout_count;
      foreach (err_count[i])
         total += err_count[i];
      $display("Errors: rx %0d, tx %0d, spi %0d, pll %0d, led %0d, timeout %0d",
               err_count[T_RX], err_count[T_TX], err_count[T_SPI], err_count[T_PLL],
               err_count[T_LED], timeout_count);
      if (total == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire
